/* verilog.f */
+incdir+.
aes_state_pkg.sv
aes_key_pkg.sv
aes_round_mix.sv
aes_round_reg.sv
aes_key_schedule.sv
aes_round_ctrl.sv
aes256_core.sv
tb_aes256.sv

/* tb_aes256.sv */
// testbench for the AES-256 core
// FIPS-197 vector, LFSR-random blocks, start/busy/done timing and hold checks

`timescale 1ns/1ps
`include "aes_defines.svh"

module tb_aes256
    import aes_state_pkg::*;
    import aes_key_pkg::*;
();

    // 40 encryptions of 20 cycles each, plus margin
    localparam int max_cycles = 40 * 20 + 10;
    localparam int done_delay = `AES_ROUNDS + 2;    // clocks from start sample to done
    localparam int num_blocks = 34;                  // C.3 + 32 random + ignored-start test

    logic        clk;
    logic        resetn;
    logic        start;
    state_t      plaintext;
    key_t        key;
    logic        busy;
    logic        done;
    state_t      ciphertext;

    logic [31:0] lfsr;          // stimulus generator state
    state_t      exp_q[$];      // expected results, oldest first
    int          cycle_cnt;
    int          run_cycles;    // clocks since the accepted start
    logic        in_run;
    int          n_checked;

    aes256_core aes256_core_inst
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    always #50 clk = ~clk;  // 100 ns period

    // error line, fail message, stop
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_state(input state_t got, input state_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("** Error at time %0t: %s, got %h expected %h",
                               $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("** Error at time %0t: %s, got %b expected %b",
                               $time, what, got, exp));
    endtask

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step_f(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_pair(output state_t pt, output key_t k);
        logic [127:0] p;
        logic [255:0] q;
        p = '0;
        q = '0;
        for (int i = 0; i < 128; i++)
        begin
            lfsr = lfsr_step_f(lfsr);
            p    = {p[126:0], lfsr[0]};     // one step per bit
        end
        for (int i = 0; i < 256; i++)
        begin
            lfsr = lfsr_step_f(lfsr);
            q    = {q[254:0], lfsr[0]};
        end
        pt = p;
        k  = q;
    endtask

    // S-box on each byte of a key word
    function automatic logic [31:0] word_sbox_f(input logic [31:0] v);
        return {sbox_f(v[31:24]), sbox_f(v[23:16]), sbox_f(v[15:8]), sbox_f(v[7:0])};
    endfunction

    // FIPS-197 cipher with full key expansion up front
    function automatic state_t aes256_ref_f(input state_t pt, input key_t k);
        logic [31:0] w [0:59];
        logic [7:0]  s [0:15];
        logic [7:0]  t [0:15];
        logic [31:0] tmp;
        logic [7:0]  rc;
        state_t      res;
        rc = 8'h01;
        for (int i = 0; i < 8; i++)
            w[i] = k[i];
        for (int i = 8; i < 60; i++)
        begin
            tmp = w[i-1];
            if (i % 8 == 0)
            begin
                tmp = word_sbox_f({tmp[23:0], tmp[31:24]}) ^ {rc, 24'h000000};
                rc  = xtime_f(rc);  // Rcon[i/8 + 1]
            end
            else if (i % 8 == 4)
                tmp = word_sbox_f(tmp);     // extra SubWord for Nk = 8
            w[i] = w[i-8] ^ tmp;
        end
        for (int i = 0; i < `AES_NB_BYTES; i++)
        begin
            tmp  = w[i/4];
            s[i] = pt[i] ^ tmp[31 - 8*(i%4) -: 8];
        end
        for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++)
        begin
            // sub bytes and shift rows, s'[r,c] = s[r,(c+r) mod 4]
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    t[4*c + r] = sbox_f(s[4*((c + r) % 4) + r]);
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    if (rnd < `AES_ROUNDS)
                        s[4*c + r] = xtime_f(t[4*c + r]) ^ xtime_f(t[4*c + (r+1)%4])
                                   ^ t[4*c + (r+1)%4] ^ t[4*c + (r+2)%4] ^ t[4*c + (r+3)%4];
                    else
                        s[4*c + r] = t[4*c + r];    // no mix in the last round
            for (int i = 0; i < `AES_NB_BYTES; i++)
            begin
                tmp  = w[4*rnd + i/4];
                s[i] = s[i] ^ tmp[31 - 8*(i%4) -: 8];
            end
        end
        for (int i = 0; i < `AES_NB_BYTES; i++)
            res[i] = s[i];
        return res;
    endfunction

    // drive on this edge, sampled on the next one
    task automatic issue_start(input state_t pt, input key_t k, input state_t exp);
        start     <= 1'b1;
        plaintext <= pt;
        key       <= k;
        exp_q.push_back(exp);
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic start_block(input state_t pt, input key_t k, input state_t exp);
        @(posedge clk);
        while (busy)
            @(posedge clk);
        issue_start(pt, k, exp);
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (!done)
            @(posedge clk);     // timeout process guards this
    endtask

    // timing of busy/done and ciphertext compare
    always @(posedge clk)
    begin
        if (resetn)
        begin
            if (in_run)
            begin
                run_cycles = run_cycles + 1;
                check_bit(busy, run_cycles < done_delay, "busy during encryption");
                check_bit(done, run_cycles == done_delay, "done timing");
                if (run_cycles == done_delay)
                begin
                    in_run = 1'b0;
                    if (exp_q.size() == 0)
                        fail_run("done pulsed with no encryption pending");
                    else
                    begin
                        check_state(ciphertext, exp_q.pop_front(), "ciphertext");
                        n_checked = n_checked + 1;
                    end
                end
            end
            else
            begin
                check_bit(busy, 1'b0, "busy while idle");
                check_bit(done, 1'b0, "done while idle");
            end
            if (start && !busy)
            begin
                in_run     = 1'b1;     // start accepted on this edge
                run_cycles = 0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= max_cycles)
            fail_run("timeout: done never arrived");
    end

    initial
    begin
        state_t pt;
        key_t   k;
        state_t exp;
        clk        = 1'b0;
        resetn     = 1'b0;
        start      = 1'b0;
        plaintext  = '0;
        key        = '0;
        lfsr       = 32'h313a;
        cycle_cnt  = 0;
        run_cycles = 0;
        in_run     = 1'b0;
        n_checked  = 0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(done, 1'b0, "done after reset");
        check_state(ciphertext, '0, "ciphertext after reset");  // zero state and key

        // FIPS-197 appendix C.3
        pt  = 128'h00112233445566778899aabbccddeeff;
        k   = 256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
        exp = 128'h8ea2b7ca516745bfeafc49904b496089;
        check_state(aes256_ref_f(pt, k), exp, "reference model on C.3");
        start_block(pt, k, exp);
        wait_done();
        repeat (5)
        begin
            @(posedge clk);
            check_state(ciphertext, exp, "ciphertext hold after done");
        end

        for (int n = 0; n < 32; n++)
        begin
            random_pair(pt, k);
            repeat (n % 3) @(posedge clk);  // 0 gives a start right after done
            issue_start(pt, k, aes256_ref_f(pt, k));
            wait_done();
        end

        // second start while busy, different inputs
        random_pair(pt, k);
        issue_start(pt, k, aes256_ref_f(pt, k));
        repeat (4) @(posedge clk);
        random_pair(pt, k);
        start     <= 1'b1;
        plaintext <= pt;
        key       <= k;
        @(posedge clk);
        start <= 1'b0;
        wait_done();

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0 || n_checked != num_blocks)
            fail_run("number of finished encryptions does not match the number started");
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* aes256_core.sv */
// AES-256 encryption core, one round per clock
// controller, state register, round logic and key schedule

`timescale 1ns/1ps

module aes256_core
    import aes_state_pkg::*;
    import aes_key_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   start,
    input  state_t plaintext,
    input  key_t   key,
    output logic   busy,
    output logic   done,
    output state_t ciphertext   // valid from done until next start
);

    round_ctrl_t ctrl;
    state_t      state;
    state_t      shifted;
    state_t      mixed;
    round_key_t  round_key;

    aes_round_ctrl aes_round_ctrl_inst
    (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .ctrl   (ctrl),
        .busy   (busy),
        .done   (done)
    );

    aes_round_reg aes_round_reg_inst
    (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .plaintext (plaintext),
        .inp_mix   (mixed),
        .inp_shf   (shifted),
        .state     (state)
    );

    // after round 13 keyed is state ^ round key 14
    aes_round_mix aes_round_mix_inst
    (
        .state     (state),
        .round_key (round_key),
        .keyed     (ciphertext),
        .shifted   (shifted),
        .mixed     (mixed)
    );

    aes_key_schedule aes_key_schedule_inst
    (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .key       (key),
        .round_key (round_key)
    );

endmodule

/* aes_round_ctrl.sv */
// AES round sequencer
// start/busy/done handling and the round counter

`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_round_ctrl
    import aes_state_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        start,
    output round_ctrl_t ctrl,
    output logic        busy,
    output logic        done
);

    ctrl_fsm_t fsm;
    round_t    round_cnt;

    // start only counts in idle
    assign ctrl.load  = start && (fsm == fsm_idle);
    assign ctrl.wr_en = (fsm == fsm_run);
    assign ctrl.round = round_cnt;

    assign busy = (fsm != fsm_idle);    // run and finish

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fsm       <= fsm_idle;
            round_cnt <= '0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (fsm)
                fsm_idle:
                begin
                    if (ctrl.load)
                    begin
                        round_cnt <= '0;
                        fsm       <= fsm_run;
                    end
                end
                fsm_run:
                begin
                    // 14 writes, rounds 0..13
                    if (round_cnt == round_t'(`AES_ROUNDS - 1))
                        fsm <= fsm_finish;
                    else
                        round_cnt <= round_cnt + round_t'(1);
                end
                fsm_finish:
                begin
                    done <= 1'b1;   // single pulse, busy drops with it
                    fsm  <= fsm_idle;
                end
                default:
                    fsm <= fsm_idle;
            endcase
        end
    end

endmodule

/* aes_key_schedule.sv */
// AES-256 key expansion, on the fly
// keeps two round keys, steps one round key per write

`timescale 1ns/1ps

module aes_key_schedule
    import aes_state_pkg::*;
    import aes_key_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  round_ctrl_t ctrl,
    input  key_t        key,
    output round_key_t  round_key   // key for the current round
);

    round_key_t next_key;   // round key after round_key
    logic [7:0] rcon;
    round_t     next_idx;   // index of the key presented after the step
    word_t      last_w;
    word_t      temp_w;
    round_key_t new_key;    // round key two ahead

    // SubWord, S-box on all four bytes
    function automatic word_t sub_word_f(input word_t w);
        word_t s;
        for (int i = 0; i < 4; i++)
            s[8*i +: 8] = sbox_f(w[8*i +: 8]);
        return s;
    endfunction

    always_comb
    begin
        next_idx = ctrl.round + round_t'(1);
        last_w   = next_key[3];

        // new 8-word group starts when the upcoming key index is odd
        if (next_idx[0])
            temp_w = sub_word_f({last_w[23:0], last_w[31:24]}) ^ {rcon, 24'h000000};
        else
            temp_w = sub_word_f(last_w);    // mid-group, no rotate

        // w[i] = w[i-8] ^ w[i-1] chain
        new_key[0] = round_key[0] ^ temp_w;
        for (int i = 1; i < 4; i++)
            new_key[i] = round_key[i] ^ new_key[i-1];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            round_key <= '0;
            next_key  <= '0;
            rcon      <= 8'h00;
        end
        else if (ctrl.load)
        begin
            round_key <= key[0:3];  // w0..w3, round key 0
            next_key  <= key[4:7];  // w4..w7, round key 1
            rcon      <= 8'h01;
        end
        else if (ctrl.wr_en)
        begin
            round_key <= next_key;
            next_key  <= new_key;
            if (next_idx[0])
                rcon <= rcon_next_f(rcon);  // used once per group
        end
    end

endmodule

/* aes_round_reg.sv */
// AES round state register
// takes the plaintext on load, then the mixed or shifted round result

`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_round_reg
    import aes_state_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  round_ctrl_t ctrl,
    input  state_t      plaintext,
    input  state_t      inp_mix,    // after mix columns
    input  state_t      inp_shf,    // after shift rows
    output state_t      state
);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= '0;
        end
        else if (ctrl.load)
        begin
            state <= plaintext;     // new block
        end
        else if (ctrl.wr_en)
        begin
            // final round has no mix columns
            if (ctrl.round == round_t'(`AES_LAST_ROUND))
                state <= inp_shf;
            else
                state <= inp_mix;
        end
    end

endmodule

/* aes_round_mix.sv */
// AES round data path, purely combinational
// add round key, sub bytes, shift rows, mix columns

`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_round_mix
    import aes_state_pkg::*;
    import aes_key_pkg::*;
(
    input  state_t     state,
    input  round_key_t round_key,
    output state_t     keyed,       // state ^ key, ciphertext after round 14
    output state_t     shifted,     // last round result
    output state_t     mixed        // rounds 1..13 result
);

    state_t subbed;

    // one column of mix columns
    function automatic logic [0:3][7:0] mix_col_f(input logic [0:3][7:0] a);
        logic [0:3][7:0] b;
        // 2a0 ^ 3a1 ^ a2 ^ a3 and rotations
        b[0] = xtime_f(a[0]) ^ xtime_f(a[1]) ^ a[1] ^ a[2] ^ a[3];
        b[1] = a[0] ^ xtime_f(a[1]) ^ xtime_f(a[2]) ^ a[2] ^ a[3];
        b[2] = a[0] ^ a[1] ^ xtime_f(a[2]) ^ xtime_f(a[3]) ^ a[3];
        b[3] = xtime_f(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime_f(a[3]);
        return b;
    endfunction

    always_comb
    begin
        // round key goes in first, so keyed doubles as the output
        keyed = state_t'(state ^ round_key);

        for (int i = 0; i < `AES_NB_BYTES; i++)
            subbed[i] = sbox_f(keyed[i]);

        // row r rotates left by r bytes
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                shifted[4*c + r] = subbed[4*((c + r) % 4) + r];
        end

        for (int c = 0; c < 4; c++)
            mixed[4*c +: 4] = mix_col_f(shifted[4*c +: 4]);  // column c
    end

endmodule

/* aes_key_pkg.sv */
// AES key package
// cipher key, key word and round key types, rcon stepping

`include "aes_defines.svh"

package aes_key_pkg;

    typedef logic [31:0] word_t;    // w[i], first byte in msb

    // eight words, w0 in the msb position
    typedef logic [0:`AES_KEY_BITS/32-1][31:0] key_t;

    // four words, same bit order as state_t
    typedef logic [0:3][31:0] round_key_t;

    // next round constant, doubling in GF(2^8)
    function automatic logic [7:0] rcon_next_f(input logic [7:0] rcon);
        logic [7:0] nxt;
        nxt = {rcon[6:0], 1'b0};
        if (rcon[7])
            nxt = nxt ^ 8'h1b;
        return nxt;
    endfunction

endpackage

/* aes_state_pkg.sv */
// AES state package
// state and control types, S-box lookup and GF(2^8) doubling

`include "aes_defines.svh"

package aes_state_pkg;

    // byte 0 is the first input byte, it sits in the msb position
    // column-major, byte 4*c + r is row r of column c
    typedef logic [0:`AES_NB_BYTES-1][7:0] state_t;

    typedef logic [3:0] round_t;    // 0..13 during the run

    // controller to register and key schedule
    typedef struct packed
    {
        logic   load;   // take plaintext and key
        logic   wr_en;  // one round step
        round_t round;  // round being written
    } round_ctrl_t;

    // sequencer states
    typedef enum logic [1:0]
    {
        fsm_idle,
        fsm_run,
        fsm_finish
    } ctrl_fsm_t;

    // forward S-box, row per high nibble
    localparam logic [0:255][7:0] sbox_table =
    {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // byte substitution, plain table lookup
    function automatic logic [7:0] sbox_f(input logic [7:0] b);
        return sbox_table[b];
    endfunction

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime_f(input logic [7:0] b);
        logic [7:0] shl;
        shl = {b[6:0], 1'b0};
        if (b[7])
            shl = shl ^ 8'h1b;  // reduce on overflow
        return shl;
    endfunction

endpackage

/* aes_defines.svh */
// AES-256 constants
// round count, last round, state bytes and key width

`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// 14 rounds for a 256-bit key
`define AES_ROUNDS 14

// mix columns is skipped on this counter value
`define AES_LAST_ROUND 13

// bytes in the 4x4 state
`define AES_NB_BYTES 16

// cipher key width in bits
`define AES_KEY_BITS 256

`endif
